// File: build.f
+incdir+rtl
rtl/lease_pkg.sv
rtl/lease_lfsr.sv
rtl/lease_lookup_table.sv
rtl/lease_register_bank.sv
rtl/lease_policy_fsm.sv
rtl/lease_policy_top.sv
sim/lease_policy_tb.sv

// File: Bender.yml
package:
  name: lease_policy

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lease_pkg.sv
      - rtl/lease_lfsr.sv
      - rtl/lease_lookup_table.sv
      - rtl/lease_register_bank.sv
      - rtl/lease_policy_fsm.sv
      - rtl/lease_policy_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/lease_policy_tb.sv

// File: sim/lease_policy_tb.sv
/* testbench for the lease policy top level: clock, reset, watchdog,
   lfsr and lease reference model, stimulus table applied in a loop */

`include "lease_consts.svh"

module lease_policy_tb;

	import lease_pkg::*;

	typedef enum int {OP_CFG, OP_LLT, OP_HIT, OP_MISS} op_e;

	typedef struct {
		op_e         op;
		logic [15:0] addr;      // search address or table write address
		logic [31:0] data;      // write data or hit line
		logic        swap;      // expected swap_o of a miss
		logic        dflt;      // expected default_o
		int          victim;    // expected addr_o or negative for model only
	} row_t;

	localparam int          num_lines = 8;
	localparam int          no_line   = -1;
	localparam logic [31:0] any_line  = '1;    // random line in the upper half

	logic        clock_i;
	logic        resetn_i;
	logic        con_wren_i;
	logic        llt_wren_i;
	logic [4:0]  llt_addr_i;
	logic [31:0] llt_data_i;
	logic [15:0] llt_search_addr_i;
	logic [2:0]  cache_addr_i;
	logic        hit_i;
	logic        miss_i;
	logic        done_o;
	logic [2:0]  addr_o;
	logic        swap_o;
	logic        expired_o;
	logic        expired_multi_o;
	logic        default_o;

	row_t        rows [$];
	bit          rows_ready;

	// reference model state
	lease_t      m_lease [num_lines];
	lease_t      m_default;
	lease_t      m_saved;          // lease for the follow-up hit
	int          m_fill_ptr;
	bit          m_fill_done;
	lfsr_word_t  m_victim_lfsr;
	lfsr_word_t  m_prob_lfsr;
	logic [15:0] m_tag   [8];
	lease_t      m_l0    [8];
	lease_t      m_l1    [8];
	prob_t       m_prob  [8];
	bit          m_valid [8];

	lease_policy_top #(.CACHE_BLOCK_CAPACITY(num_lines)) i_dut (
		.clock_i           (clock_i),
		.resetn_i          (resetn_i),
		.con_wren_i        (con_wren_i),
		.llt_wren_i        (llt_wren_i),
		.llt_addr_i        (llt_addr_i),
		.llt_data_i        (llt_data_i),
		.llt_search_addr_i (llt_search_addr_i),
		.cache_addr_i      (cache_addr_i),
		.hit_i             (hit_i),
		.miss_i            (miss_i),
		.done_o            (done_o),
		.addr_o            (addr_o),
		.swap_o            (swap_o),
		.expired_o         (expired_o),
		.expired_multi_o   (expired_multi_o),
		.default_o         (default_o)
	);

	initial begin
		clock_i = 1'b0;
		forever #50 clock_i = ~clock_i;
	end

	// ----------------------------------------------------------------------
	// reporting and model helpers
	// ----------------------------------------------------------------------
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp)
		else report_failure($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// x^9 + x^5 + 1 feedback with a left shift
	function automatic lfsr_word_t lfsr_next(input lfsr_word_t v);
		return {v[7:0], v[8] ^ v[4]};
	endfunction

	// lowest matching valid entry wins, otherwise the default lease
	task automatic model_lease(input logic [15:0] search, output lease_t lease,
			output bit tbl_hit);
		tbl_hit = 1'b0;
		lease   = m_default;
		for (int e = 0; e < 8 && !tbl_hit; e++) begin
			if (m_valid[e] && m_tag[e] == search) begin
				tbl_hit = 1'b1;
				lease   = (m_prob_lfsr < m_prob[e]) ? m_l0[e] : m_l1[e];
			end
		end
		m_prob_lfsr = lfsr_next(m_prob_lfsr);     // steps on every access
	endtask

	task automatic model_decrement(input int keep);
		for (int j = 0; j < num_lines; j++) begin
			if (j != keep && m_lease[j] != '0) m_lease[j]--;   // saturates at zero
		end
	endtask

	task automatic add_row(input op_e op, input logic [15:0] addr, input logic [31:0] data,
			input logic swap, input logic dflt, input int victim);
		row_t r;
		r = '{op, addr, data, swap, dflt, victim};
		rows.push_back(r);
	endtask

	// ----------------------------------------------------------------------
	// bus operations
	// ----------------------------------------------------------------------
	task automatic do_write(input row_t r);
		llt_addr_i = r.addr[4:0];
		llt_data_i = r.data;
		if (r.op == OP_CFG) begin
			con_wren_i = 1'b1;
			m_default  = r.data[7:0];
		end else begin
			llt_wren_i = 1'b1;
			case (llt_table_e'(r.addr[4:3]))
				TBL_TAG: begin
					m_tag[r.addr[2:0]]   = r.data[15:0];
					m_valid[r.addr[2:0]] = 1'b1;
				end
				TBL_LEASE0: m_l0[r.addr[2:0]]   = r.data[7:0];
				TBL_LEASE1: m_l1[r.addr[2:0]]   = r.data[7:0];
				TBL_PROB:   m_prob[r.addr[2:0]] = r.data[8:0];
			endcase
		end
		@(negedge clock_i);
		con_wren_i = 1'b0;
		llt_wren_i = 1'b0;
	endtask

	task automatic do_hit(input logic [2:0] line, input logic [15:0] search,
			input bit followup, input logic exp_dflt);
		lease_t lease;
		bit     tbl_hit;
		model_lease(search, lease, tbl_hit);
		if (followup) begin
			lease = m_saved;                  // no decrement on a follow-up
		end else begin
			model_decrement(line);            // renew wins on its own line
		end
		m_lease[line]     = lease;
		hit_i             = 1'b1;
		cache_addr_i      = line;
		llt_search_addr_i = search;
		@(negedge clock_i);
		hit_i = 1'b0;
		check_value("default_o", default_o, exp_dflt);
		check_value("done_o", done_o, 1'b0);
	endtask

	task automatic do_miss(input row_t r);
		lease_t lease;
		bit     tbl_hit;
		int     victim;
		int     n_exp;
		int     first;
		int     latency;
		logic   exp_expired;
		logic   exp_multi;
		model_lease(r.addr, lease, tbl_hit);
		model_decrement(no_line);
		m_saved     = lease;
		victim      = 0;
		exp_expired = 1'b0;
		exp_multi   = 1'b0;
		n_exp       = 0;
		first       = -1;
		for (int j = 0; j < num_lines; j++) begin
			if (m_lease[j] == '0) begin
				n_exp++;
				if (first < 0) first = j;
			end
		end
		if (lease != '0) begin
			if (!m_fill_done) begin
				victim      = m_fill_ptr;                      // cold-start order
				m_fill_ptr  = (m_fill_ptr + 1) % num_lines;
				m_fill_done = (m_fill_ptr == 0);
			end else if (n_exp > 0) begin
				victim      = first;
				exp_expired = 1'b1;
				exp_multi   = (n_exp >= 2);
			end else begin
				victim        = m_victim_lfsr[3:1];              // used, then stepped
				m_victim_lfsr = lfsr_next(m_victim_lfsr);
			end
		end
		miss_i            = 1'b1;
		llt_search_addr_i = r.addr;
		@(negedge clock_i);
		miss_i  = 1'b0;
		latency = 1;
		check_value("default_o", default_o, r.dflt);
		while (!done_o) begin
			if (latency >= 4) report_failure("done_o never pulsed after a miss");
			@(negedge clock_i);
			latency++;
		end
		check_value("miss latency", latency, (lease != '0) ? 2 : 1);
		check_value("swap_o", swap_o, r.swap);
		check_value("expired_o", expired_o, exp_expired);
		check_value("expired_multi_o", expired_multi_o, exp_multi);
		if (lease != '0) begin
			check_value("addr_o", addr_o, victim);
			if (r.victim >= 0) check_value("addr_o", addr_o, r.victim);
			do_hit(addr_o, r.addr, 1'b1, 1'b0);                  // follow-up on the victim
		end
	endtask

	// ----------------------------------------------------------------------
	// stimulus table
	// ----------------------------------------------------------------------
	task automatic build_table();
		add_row(OP_MISS, 16'h0100, 32'd0, 1'b0, 1'b1, no_line);   // zero default lease
		add_row(OP_CFG,  16'h0000, 32'd5, 1'b0, 1'b0, no_line);
		for (int k = 0; k < num_lines; k++) begin
			add_row(OP_MISS, 16'h0200, 32'd0, 1'b1, 1'b1, k);      // fill lines in order
		end
		// entry 0 picks lease0 at prob 511 and entry 1 picks its zero lease1 at prob 0
		add_row(OP_LLT, 16'h0000, 32'h0300, 1'b0, 1'b0, no_line);
		add_row(OP_LLT, 16'h0008, 32'd3,    1'b0, 1'b0, no_line);
		add_row(OP_LLT, 16'h0010, 32'd9,    1'b0, 1'b0, no_line);
		add_row(OP_LLT, 16'h0018, 32'd511,  1'b0, 1'b0, no_line);
		add_row(OP_LLT, 16'h0001, 32'h0400, 1'b0, 1'b0, no_line);
		add_row(OP_LLT, 16'h0009, 32'd7,    1'b0, 1'b0, no_line);
		add_row(OP_LLT, 16'h0011, 32'd0,    1'b0, 1'b0, no_line);
		add_row(OP_LLT, 16'h0019, 32'd0,    1'b0, 1'b0, no_line);
		add_row(OP_HIT, 16'h0300, 32'd0, 1'b0, 1'b0, no_line);    // line 0 gets 3 from table
		for (int k = 0; k < 3; k++) begin
			add_row(OP_HIT, 16'h0200, any_line, 1'b0, 1'b1, no_line);
		end
		add_row(OP_MISS, 16'h0200, 32'd0, 1'b1, 1'b1, 0);         // lines 0..3 expired
		add_row(OP_CFG,  16'h0000, 32'd20, 1'b0, 1'b0, no_line);
		for (int k = 1; k < num_lines; k++) begin
			add_row(OP_HIT, 16'h0200, k, 1'b0, 1'b1, no_line);
		end
		add_row(OP_MISS, 16'h0200, 32'd0, 1'b1, 1'b1, 0);         // only line 0 expired
		add_row(OP_MISS, 16'h0200, 32'd0, 1'b1, 1'b1, no_line);   // random fallback
		add_row(OP_MISS, 16'h0200, 32'd0, 1'b1, 1'b1, no_line);
		add_row(OP_MISS, 16'h0400, 32'd0, 1'b0, 1'b0, no_line);   // zero lease from table
	endtask

	// watchdog sized by the table
	initial begin
		wait (rows_ready);
		repeat (rows.size() * 4 + 16) @(posedge clock_i);
		report_failure("watchdog timeout, the stimulus table did not complete");
	end

	initial begin
		logic [2:0] line;
		void'($urandom(21233));
		resetn_i          = 1'b0;
		con_wren_i        = 1'b0;
		llt_wren_i        = 1'b0;
		llt_addr_i        = '0;
		llt_data_i        = '0;
		llt_search_addr_i = '0;
		cache_addr_i      = '0;
		hit_i             = 1'b0;
		miss_i            = 1'b0;
		foreach (m_lease[j]) m_lease[j] = '0;
		foreach (m_valid[e]) m_valid[e] = 1'b0;
		m_default     = '0;
		m_saved       = '0;
		m_fill_ptr    = 0;
		m_fill_done   = 1'b0;
		m_victim_lfsr = `LEASE_SEED_VICTIM;
		m_prob_lfsr   = `LEASE_SEED_PROB;
		build_table();
		rows_ready = 1'b1;
		repeat (16) @(negedge clock_i);
		resetn_i = 1'b1;
		check_value("done_o", done_o, 1'b0);
		check_value("addr_o", addr_o, 3'd0);
		check_value("swap_o", swap_o, 1'b0);
		check_value("expired_o", expired_o, 1'b0);
		check_value("expired_multi_o", expired_multi_o, 1'b0);
		check_value("default_o", default_o, 1'b0);
		foreach (rows[i]) begin
			case (rows[i].op)
				OP_CFG, OP_LLT: do_write(rows[i]);
				OP_HIT: begin
					line = (rows[i].data == any_line) ? 3'(4 + $urandom % 4) : rows[i].data[2:0];
					do_hit(line, rows[i].addr, 1'b0, rows[i].dflt);
				end
				OP_MISS: do_miss(rows[i]);
			endcase
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: rtl/lease_policy_top.sv
/* lease policy top level: lookup table, probability and victim lfsrs,
   lease register bank and controller */

`include "lease_consts.svh"

module lease_policy_top #(
	parameter  int CACHE_BLOCK_CAPACITY = `LEASE_CACHE_LINES,
	localparam int LINE_BW              = $clog2(CACHE_BLOCK_CAPACITY)
) (
	input  logic                                  clock_i,
	input  logic                                  resetn_i,

	// configuration and table writes
	input  logic                                  con_wren_i,
	input  logic                                  llt_wren_i,
	input  logic [$clog2(`LEASE_LLT_ENTRIES)+1:0] llt_addr_i,
	input  logic [31:0]                           llt_data_i,
	input  lease_pkg::ref_addr_t                  llt_search_addr_i,

	// accesses
	input  logic [LINE_BW-1:0]                    cache_addr_i,
	input  logic                                  hit_i,
	input  logic                                  miss_i,

	// results
	output logic                                  done_o,
	output logic [LINE_BW-1:0]                    addr_o,
	output logic                                  swap_o,
	output logic                                  expired_o,
	output logic                                  expired_multi_o,
	output logic                                  default_o
);

	import lease_pkg::*;

	logic               llt_hit;
	lease_t             lease0;
	lease_t             lease1;
	prob_t              lease0_prob;
	lfsr_word_t         prob_rand;
	lfsr_word_t         victim_rand;
	logic               prob_step;
	logic               victim_step;
	logic               decr;
	logic               renew;
	logic [LINE_BW-1:0] renew_line;
	lease_t             renew_value;
	logic               fill_step;
	logic               any_expired;
	logic [LINE_BW-1:0] first_expired;
	logic [LINE_BW-1:0] last_expired;
	logic [LINE_BW-1:0] fill_ptr;
	logic               fill_done;

	// ----------------------------------------------------------------------
	// lookup and random sources
	// ----------------------------------------------------------------------
	lease_lookup_table i_llt (
		.clock_i       (clock_i),
		.resetn_i      (resetn_i),
		.wren_i        (llt_wren_i),
		.addr_i        (llt_addr_i),
		.data_i        (llt_data_i),
		.search_addr_i (llt_search_addr_i),
		.hit_o         (llt_hit),
		.lease0_o      (lease0),
		.lease1_o      (lease1),
		.lease0_prob_o (lease0_prob)
	);

	lease_lfsr #(.SEED(`LEASE_SEED_PROB)) i_prob_lfsr (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.enable_i (prob_step),
		.value_o  (prob_rand)
	);

	lease_lfsr #(.SEED(`LEASE_SEED_VICTIM)) i_victim_lfsr (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.enable_i (victim_step),
		.value_o  (victim_rand)
	);

	// ----------------------------------------------------------------------
	// lease state and control
	// ----------------------------------------------------------------------
	lease_register_bank #(.CACHE_BLOCK_CAPACITY(CACHE_BLOCK_CAPACITY)) i_bank (
		.clock_i         (clock_i),
		.resetn_i        (resetn_i),
		.decr_i          (decr),
		.renew_i         (renew),
		.renew_line_i    (renew_line),
		.renew_value_i   (renew_value),
		.fill_step_i     (fill_step),
		.any_expired_o   (any_expired),
		.first_expired_o (first_expired),
		.last_expired_o  (last_expired),
		.fill_ptr_o      (fill_ptr),
		.fill_done_o     (fill_done)
	);

	lease_policy_fsm #(.CACHE_BLOCK_CAPACITY(CACHE_BLOCK_CAPACITY)) i_fsm (
		.clock_i         (clock_i),
		.resetn_i        (resetn_i),
		.con_wren_i      (con_wren_i),
		.llt_addr_i      (llt_addr_i),
		.llt_data_i      (llt_data_i),
		.hit_i           (hit_i),
		.miss_i          (miss_i),
		.cache_addr_i    (cache_addr_i),
		.llt_hit_i       (llt_hit),
		.lease0_i        (lease0),
		.lease1_i        (lease1),
		.lease0_prob_i   (lease0_prob),
		.prob_rand_i     (prob_rand),
		.victim_rand_i   (victim_rand),
		.any_expired_i   (any_expired),
		.first_expired_i (first_expired),
		.last_expired_i  (last_expired),
		.fill_ptr_i      (fill_ptr),
		.fill_done_i     (fill_done),
		.prob_step_o     (prob_step),
		.victim_step_o   (victim_step),
		.decr_o          (decr),
		.renew_o         (renew),
		.renew_line_o    (renew_line),
		.renew_value_o   (renew_value),
		.fill_step_o     (fill_step),
		.done_o          (done_o),
		.addr_o          (addr_o),
		.swap_o          (swap_o),
		.expired_o       (expired_o),
		.expired_multi_o (expired_multi_o),
		.default_o       (default_o)
	);

endmodule

// File: rtl/lease_policy_fsm.sv
/* lease policy controller: default lease register, probabilistic lease pick,
   renew/decrement sequencing, victim selection and registered result flags */

`include "lease_consts.svh"

module lease_policy_fsm #(
	parameter  int CACHE_BLOCK_CAPACITY = `LEASE_CACHE_LINES,
	localparam int LINE_BW              = $clog2(CACHE_BLOCK_CAPACITY)
) (
	input  logic                                  clock_i,
	input  logic                                  resetn_i,

	// configuration write
	input  logic                                  con_wren_i,
	input  logic [$clog2(`LEASE_LLT_ENTRIES)+1:0] llt_addr_i,
	input  logic [31:0]                           llt_data_i,

	// access strobes from the cache controller
	input  logic                                  hit_i,
	input  logic                                  miss_i,
	input  logic [LINE_BW-1:0]                    cache_addr_i,

	// lookup table and lfsr values
	input  logic                                  llt_hit_i,
	input  lease_pkg::lease_t                     lease0_i,
	input  lease_pkg::lease_t                     lease1_i,
	input  lease_pkg::prob_t                      lease0_prob_i,
	input  lease_pkg::lfsr_word_t                 prob_rand_i,
	input  lease_pkg::lfsr_word_t                 victim_rand_i,

	// register bank status
	input  logic                                  any_expired_i,
	input  logic [LINE_BW-1:0]                    first_expired_i,
	input  logic [LINE_BW-1:0]                    last_expired_i,
	input  logic [LINE_BW-1:0]                    fill_ptr_i,
	input  logic                                  fill_done_i,

	// lfsr steps and register bank commands
	output logic                                  prob_step_o,
	output logic                                  victim_step_o,
	output logic                                  decr_o,
	output logic                                  renew_o,
	output logic [LINE_BW-1:0]                    renew_line_o,
	output lease_pkg::lease_t                     renew_value_o,
	output logic                                  fill_step_o,

	// results to the cache controller
	output logic                                  done_o,
	output logic [LINE_BW-1:0]                    addr_o,
	output logic                                  swap_o,
	output logic                                  expired_o,
	output logic                                  expired_multi_o,
	output logic                                  default_o
);

	import lease_pkg::*;

	policy_state_e state_q;
	lease_t        default_lease_q;
	lease_t        saved_lease_q;    // lease for the follow-up hit
	logic          followup_q;       // next hit completes a miss
	lease_t        chosen_lease;
	lease_t        access_lease;
	logic          access_hit;
	logic          access_miss;
	logic          in_victim;

	// ----------------------------------------------------------------------
	// lease choice
	// ----------------------------------------------------------------------
	assign chosen_lease = (prob_rand_i < lease0_prob_i) ? lease0_i : lease1_i;
	assign access_lease = llt_hit_i ? chosen_lease : default_lease_q;

	// strobes only count while idle
	assign access_hit  = (state_q == ST_NORMAL) && hit_i;
	assign access_miss = (state_q == ST_NORMAL) && miss_i;
	assign in_victim   = (state_q == ST_GEN_VICTIM);

	// bank commands act on the same edge that samples the strobe
	assign prob_step_o   = access_hit || access_miss;
	assign decr_o        = access_miss || (access_hit && !followup_q);
	assign renew_o       = access_hit;
	assign renew_line_o  = cache_addr_i;
	assign renew_value_o = followup_q ? saved_lease_q : access_lease;
	assign fill_step_o   = in_victim && !fill_done_i;
	assign victim_step_o = in_victim && fill_done_i && !any_expired_i;  // random pick consumed

	// default lease config register at address 0
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			default_lease_q <= '0;
		end else if (con_wren_i && llt_addr_i == '0) begin
			default_lease_q <= llt_data_i[`LEASE_VALUE_BW-1:0];
		end
	end

	always_ff @(posedge clock_i) begin
		if (access_miss) saved_lease_q <= access_lease;
	end

	// ----------------------------------------------------------------------
	// sequencing and result flags
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q         <= ST_NORMAL;
			followup_q      <= 1'b0;
			done_o          <= 1'b0;
			addr_o          <= '0;
			swap_o          <= 1'b0;
			expired_o       <= 1'b0;
			expired_multi_o <= 1'b0;
			default_o       <= 1'b0;
		end else begin
			// one-cycle pulses
			done_o          <= 1'b0;
			expired_o       <= 1'b0;
			expired_multi_o <= 1'b0;
			default_o       <= 1'b0;

			case (state_q)
				ST_NORMAL: begin
					if (hit_i) begin
						followup_q <= 1'b0;
						default_o  <= !followup_q && !llt_hit_i;  // follow-up uses saved lease
					end
					if (miss_i) begin
						default_o <= !llt_hit_i;
						if (access_lease != '0) begin
							state_q    <= ST_GEN_VICTIM;   // line must be allocated
							followup_q <= 1'b1;
						end else begin
							done_o <= 1'b1;                 // serve without allocating
							swap_o <= 1'b0;
						end
					end
				end

				ST_GEN_VICTIM: begin
					done_o  <= 1'b1;
					swap_o  <= 1'b1;
					state_q <= ST_NORMAL;
					if (!fill_done_i) begin
						addr_o <= fill_ptr_i;                      // cold-start order
					end else if (any_expired_i) begin
						addr_o          <= first_expired_i;        // lowest expired line
						expired_o       <= 1'b1;
						expired_multi_o <= (first_expired_i != last_expired_i);
					end else begin
						addr_o <= victim_rand_i[LINE_BW:1];        // random fallback
					end
				end
			endcase
		end
	end

endmodule

// File: rtl/lease_register_bank.sv
/* per-line lease countdown registers, expired flags with lowest and highest
   expired-line scans, and the cold-start fill counter */

`include "lease_consts.svh"

module lease_register_bank #(
	parameter  int CACHE_BLOCK_CAPACITY = `LEASE_CACHE_LINES,
	localparam int LINE_BW              = $clog2(CACHE_BLOCK_CAPACITY)
) (
	input  logic               clock_i,
	input  logic               resetn_i,

	// commands from the controller
	input  logic               decr_i,          // count down every non-zero lease
	input  logic               renew_i,         // load one line, wins over decr_i
	input  logic [LINE_BW-1:0] renew_line_i,
	input  lease_pkg::lease_t  renew_value_i,
	input  logic               fill_step_i,     // advance cold-start pointer

	// status
	output logic               any_expired_o,
	output logic [LINE_BW-1:0] first_expired_o, // lowest line at zero
	output logic [LINE_BW-1:0] last_expired_o,  // highest line at zero
	output logic [LINE_BW-1:0] fill_ptr_o,
	output logic               fill_done_o      // every line filled once
);

	import lease_pkg::*;

	lease_t                          leases [CACHE_BLOCK_CAPACITY];
	logic [CACHE_BLOCK_CAPACITY-1:0] expired;

	// ----------------------------------------------------------------------
	// lease countdowns
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int j = 0; j < CACHE_BLOCK_CAPACITY; j++) begin
				leases[j] <= '0;
			end
		end else begin
			for (int j = 0; j < CACHE_BLOCK_CAPACITY; j++) begin
				if (renew_i && renew_line_i == LINE_BW'(j)) begin
					leases[j] <= renew_value_i;
				end else if (decr_i && leases[j] != '0) begin
					leases[j] <= leases[j] - 1'b1;     // stops at zero
				end
			end
		end
	end

	// cold start, lines are handed out in order until the pointer wraps
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			fill_ptr_o  <= '0;
			fill_done_o <= 1'b0;
		end else if (fill_step_i) begin
			fill_ptr_o <= fill_ptr_o + 1'b1;
			if (fill_ptr_o == LINE_BW'(CACHE_BLOCK_CAPACITY-1)) begin
				fill_done_o <= 1'b1;                // sticky until reset
			end
		end
	end

	// ----------------------------------------------------------------------
	// expired line scans
	// ----------------------------------------------------------------------
	always_comb begin
		for (int j = 0; j < CACHE_BLOCK_CAPACITY; j++) begin
			expired[j] = (leases[j] == '0);
		end
	end

	assign any_expired_o = |expired;

	// downward scan leaves the lowest index
	always_comb begin
		first_expired_o = '0;
		for (int j = CACHE_BLOCK_CAPACITY-1; j >= 0; j--) begin
			if (expired[j]) first_expired_o = LINE_BW'(j);
		end
	end

	// upward scan leaves the highest index
	always_comb begin
		last_expired_o = '0;
		for (int j = 0; j < CACHE_BLOCK_CAPACITY; j++) begin
			if (expired[j]) last_expired_o = LINE_BW'(j);
		end
	end

endmodule

// File: rtl/lease_lookup_table.sv
/* programmable lease lookup table: tag, two leases and a probability per entry,
   registered writes by table select and a parallel combinational search */

`include "lease_consts.svh"

module lease_lookup_table (
	input  logic                                  clock_i,
	input  logic                                  resetn_i,

	// write port, table select in the two top address bits
	input  logic                                  wren_i,
	input  logic [$clog2(`LEASE_LLT_ENTRIES)+1:0] addr_i,
	input  logic [31:0]                           data_i,

	// search port
	input  lease_pkg::ref_addr_t                  search_addr_i,
	output logic                                  hit_o,         // some valid tag matches
	output lease_pkg::lease_t                     lease0_o,
	output lease_pkg::lease_t                     lease1_o,
	output lease_pkg::prob_t                      lease0_prob_o
);

	import lease_pkg::*;

	localparam int ENTRY_BW = $clog2(`LEASE_LLT_ENTRIES);
	localparam int ADDR_BW  = ENTRY_BW + 2;

	ref_addr_t                      tags   [`LEASE_LLT_ENTRIES];
	lease_t                         lease0 [`LEASE_LLT_ENTRIES];
	lease_t                         lease1 [`LEASE_LLT_ENTRIES];
	prob_t                          prob   [`LEASE_LLT_ENTRIES];
	logic [`LEASE_LLT_ENTRIES-1:0]  valid;
	llt_table_e                     wr_table;
	logic [ENTRY_BW-1:0]            wr_entry;

	assign wr_table = llt_table_e'(addr_i[ADDR_BW-1 -: 2]);
	assign wr_entry = addr_i[ENTRY_BW-1:0];

	// ----------------------------------------------------------------------
	// writes
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid <= '0;                        // table starts empty
		end else if (wren_i && wr_table == TBL_TAG) begin
			valid[wr_entry] <= 1'b1;            // entry is live once its tag is written
		end
	end

	// payload arrays
	always_ff @(posedge clock_i) begin
		if (wren_i) begin
			case (wr_table)
				TBL_TAG:    tags[wr_entry]   <= data_i[`LEASE_REF_ADDR_BW-1:0];
				TBL_LEASE0: lease0[wr_entry] <= data_i[`LEASE_VALUE_BW-1:0];
				TBL_LEASE1: lease1[wr_entry] <= data_i[`LEASE_VALUE_BW-1:0];
				TBL_PROB:   prob[wr_entry]   <= data_i[`LEASE_PROB_BW-1:0];
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// search
	// ----------------------------------------------------------------------
	// scan from the top so the lowest matching entry is the last to assign
	always_comb begin
		hit_o         = 1'b0;
		lease0_o      = '0;
		lease1_o      = '0;
		lease0_prob_o = '0;
		for (int e = `LEASE_LLT_ENTRIES-1; e >= 0; e--) begin
			if (valid[e] && tags[e] == search_addr_i) begin
				hit_o         = 1'b1;
				lease0_o      = lease0[e];
				lease1_o      = lease1[e];
				lease0_prob_o = prob[e];
			end
		end
	end

endmodule

// File: rtl/lease_lfsr.sv
/* 9b fibonacci lfsr, x^9 + x^5 + 1, one step per enable strobe */

module lease_lfsr #(
	parameter lease_pkg::lfsr_word_t SEED = 9'h1   // must be non-zero
) (
	input  logic                  clock_i,
	input  logic                  resetn_i,
	input  logic                  enable_i,   // advance after the value was consumed
	output lease_pkg::lfsr_word_t value_o
);

	// shift left, feedback from bits 8 and 4 into bit 0
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			value_o <= SEED;
		end else if (enable_i) begin
			value_o <= {value_o[7:0], value_o[8] ^ value_o[4]};
		end
	end

endmodule

// File: rtl/lease_pkg.sv
/* shared types of the lease policy block: lease, probability, lfsr word,
   reference address, table select codes and controller states */

`include "lease_consts.svh"

package lease_pkg;

	typedef logic [`LEASE_VALUE_BW-1:0]    lease_t;     // one countdown value
	typedef logic [`LEASE_PROB_BW-1:0]     prob_t;      // chance of picking lease0
	typedef logic [8:0]                    lfsr_word_t; // 9b shift register state
	typedef logic [`LEASE_REF_ADDR_BW-1:0] ref_addr_t;  // word address of the access

	// upper two bits of a table write address
	typedef enum logic [1:0] {
		TBL_TAG    = 2'd0,  // reference address, also sets valid
		TBL_LEASE0 = 2'd1,
		TBL_LEASE1 = 2'd2,
		TBL_PROB   = 2'd3
	} llt_table_e;

	// controller states
	typedef enum logic {
		ST_NORMAL,      // serve hits and misses
		ST_GEN_VICTIM   // pick the line to replace
	} policy_state_e;

endpackage

// File: rtl/lease_consts.svh
/* widths, table size, default capacity and lfsr seeds of the lease policy block */

`ifndef LEASE_CONSTS_SVH
`define LEASE_CONSTS_SVH

// ----------------------------------------------------------------------
// data widths
// ----------------------------------------------------------------------
`define LEASE_VALUE_BW      8       // bits per lease register
`define LEASE_REF_ADDR_BW   16      // word address from the core
`define LEASE_PROB_BW       9       // lease0 probability, compared against a 9b lfsr

// ----------------------------------------------------------------------
// sizes
// ----------------------------------------------------------------------
`define LEASE_LLT_ENTRIES   8       // entries per lookup table
`define LEASE_CACHE_LINES   8       // default number of cache lines

// lfsr start values, both non-zero
`define LEASE_SEED_PROB     9'h1AB
`define LEASE_SEED_VICTIM   9'h155

`endif
